// File: design/decode_macros.svh
`ifndef DECODE_MACROS_SVH
`define DECODE_MACROS_SVH

// machine word, used for data and addresses
`define DATA_W 32

// general register file geometry
`define REG_COUNT 32
`define REG_ADDR_W 5

// boot vector, loaded into pc while rst_n is low
`define RESET_PC 32'hbfc0_0000

`endif

// File: design/isa_pkg.sv
`default_nettype none

`include "decode_macros.svh"

package isa_pkg;

    localparam int SEL_W = 3; // cop0 select field

    // rs field values under COP0
    localparam logic [`REG_ADDR_W-1:0] COP0_MF = 5'd0;
    localparam logic [`REG_ADDR_W-1:0] COP0_MT = 5'd4;

    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        J       = 6'h02,
        JAL     = 6'h03,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        ADDIU   = 6'h09,
        SLTI    = 6'h0a,
        ANDI    = 6'h0c,
        ORI     = 6'h0d,
        LUI     = 6'h0f,
        COP0    = 6'h10,
        LW      = 6'h23,
        SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        SLL  = 6'h00,
        JR   = 6'h08,
        MFHI = 6'h10,
        MTHI = 6'h11,
        MFLO = 6'h12,
        MTLO = 6'h13,
        MULT = 6'h18,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        SLT  = 6'h2a
    } funct_e;

    // overlapping views of one instruction word
    typedef struct packed {
        opcode_e                 opcode;
        logic [`REG_ADDR_W-1:0]  rs;
        logic [`REG_ADDR_W-1:0]  rt;
        logic [`REG_ADDR_W-1:0]  rd;
        logic [4:0]              shamt;
        funct_e                  funct;
        logic [SEL_W-1:0]        sel;
        logic [15:0]             imm;
    } fields_t;

    function automatic fields_t unpack(input logic [`DATA_W-1:0] instruction);
        fields_t f;
        f.opcode = opcode_e'(instruction[31:26]);
        f.rs     = instruction[25:21];
        f.rt     = instruction[20:16];
        f.rd     = instruction[15:11];
        f.shamt  = instruction[10:6];
        f.funct  = funct_e'(instruction[5:0]);
        f.sel    = instruction[SEL_W-1:0]; // mfc0/mtc0 select
        f.imm    = instruction[15:0];
        return f;
    endfunction

endpackage

`default_nettype wire

// File: design/pipe_pkg.sv
`default_nettype none

`include "decode_macros.svh"

package pipe_pkg;

    typedef enum logic [3:0] {
        NOP  = 4'd0,
        ADD  = 4'd1,
        SUB  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        SLT  = 4'd5,
        SLL  = 4'd6,
        LUI  = 4'd7,
        PASS = 4'd8  // operand a straight through
    } alu_op_e;

    // decoded control word, carried down the pipe
    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;     // operand b from immediate
        logic    sign_ext;
        logic    write_reg;
        logic    dest_is_rt;  // else rd
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jump;
        logic    jump_reg;
        logic    link;        // return address to r31
        logic    write_hi;
        logic    write_lo;
        logic    read_cop0;
        logic    write_cop0;
    } control_t;

    // one result source from a later stage
    typedef struct packed {
        logic                   valid;
        logic [`REG_ADDR_W-1:0] idx;
        logic [`DATA_W-1:0]     data;
    } fwd_t;

endpackage

`default_nettype wire

// File: design/writeback_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

interface writeback_if;

    logic                          write_reg;
    logic [`REG_ADDR_W-1:0]        dest_reg;
    logic [`DATA_W-1:0]            dest_reg_data;
    logic                          write_cop0;
    logic [`REG_ADDR_W-1:0]        dest_cop0_rd;
    logic [isa_pkg::SEL_W-1:0]     dest_cop0_sel;
    logic [`DATA_W-1:0]            dest_cop0_data;
    logic                          write_hi;
    logic                          write_lo;
    logic [`DATA_W-1:0]            dest_hi_data;
    logic [`DATA_W-1:0]            dest_lo_data;

    modport source (output write_reg, dest_reg, dest_reg_data, write_cop0, dest_cop0_rd,
                    dest_cop0_sel, dest_cop0_data, write_hi, write_lo, dest_hi_data,
                    dest_lo_data);
    modport gpr (input write_reg, dest_reg, dest_reg_data);
    modport cop0 (input write_cop0, dest_cop0_rd, dest_cop0_sel, dest_cop0_data);
    modport bypass (input write_reg, dest_reg, dest_reg_data, write_hi, write_lo,
                    dest_hi_data, dest_lo_data);

endinterface

`default_nettype wire

// File: design/main_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module main_decoder (
    input  logic [`DATA_W-1:0] instruction,
    output pipe_pkg::control_t control
);

    isa_pkg::fields_t f;

    assign f = isa_pkg::unpack(instruction);

    always_comb begin
        control = '0; // alu_op NOP, nothing enabled
        // all-zero word is the pipeline nop, not a real sll
        if (instruction != '0) begin
            case (f.opcode)
                isa_pkg::SPECIAL: begin
                    control.write_reg = 1'b1; // rd destination
                    case (f.funct)
                        isa_pkg::ADDU: control.alu_op = pipe_pkg::ADD;
                        isa_pkg::SUBU: control.alu_op = pipe_pkg::SUB;
                        isa_pkg::AND:  control.alu_op = pipe_pkg::AND;
                        isa_pkg::OR:   control.alu_op = pipe_pkg::OR;
                        isa_pkg::SLT:  control.alu_op = pipe_pkg::SLT;
                        isa_pkg::SLL:  control.alu_op = pipe_pkg::SLL;
                        isa_pkg::MFHI, isa_pkg::MFLO: control.alu_op = pipe_pkg::PASS;
                        isa_pkg::JR: begin
                            control.write_reg = 1'b0;
                            control.jump_reg  = 1'b1;
                        end
                        isa_pkg::MTHI: begin
                            control.write_reg = 1'b0;
                            control.alu_op    = pipe_pkg::PASS;
                            control.write_hi  = 1'b1;
                        end
                        isa_pkg::MTLO: begin
                            control.write_reg = 1'b0;
                            control.alu_op    = pipe_pkg::PASS;
                            control.write_lo  = 1'b1;
                        end
                        isa_pkg::MULT: begin
                            control.write_reg = 1'b0; // product lands in hi/lo
                            control.write_hi  = 1'b1;
                            control.write_lo  = 1'b1;
                        end
                        default: control = '0;
                    endcase
                end
                isa_pkg::J: control.jump = 1'b1;
                isa_pkg::JAL: begin
                    control.jump      = 1'b1;
                    control.link      = 1'b1;
                    control.write_reg = 1'b1;
                end
                isa_pkg::BEQ, isa_pkg::BNE: begin
                    control.alu_op = pipe_pkg::SUB; // compare by subtraction
                    control.branch = 1'b1;
                end
                isa_pkg::ADDIU, isa_pkg::SLTI, isa_pkg::ANDI, isa_pkg::ORI,
                isa_pkg::LUI, isa_pkg::LW, isa_pkg::SW: begin
                    control.use_imm    = 1'b1;
                    control.write_reg  = (f.opcode != isa_pkg::SW);
                    control.dest_is_rt = (f.opcode != isa_pkg::SW);
                    control.mem_read   = (f.opcode == isa_pkg::LW);
                    control.mem_write  = (f.opcode == isa_pkg::SW);
                    // logical ops zero-extend
                    control.sign_ext   = !(f.opcode inside {isa_pkg::ANDI, isa_pkg::ORI,
                                                            isa_pkg::LUI});
                    case (f.opcode)
                        isa_pkg::SLTI: control.alu_op = pipe_pkg::SLT;
                        isa_pkg::ANDI: control.alu_op = pipe_pkg::AND;
                        isa_pkg::ORI:  control.alu_op = pipe_pkg::OR;
                        isa_pkg::LUI:  control.alu_op = pipe_pkg::LUI;
                        default:       control.alu_op = pipe_pkg::ADD; // address or sum
                    endcase
                end
                isa_pkg::COP0: begin
                    if (f.rs == isa_pkg::COP0_MF) begin
                        control.alu_op     = pipe_pkg::PASS;
                        control.read_cop0  = 1'b1;
                        control.write_reg  = 1'b1;
                        control.dest_is_rt = 1'b1;
                    end else if (f.rs == isa_pkg::COP0_MT) begin
                        control.alu_op     = pipe_pkg::PASS;
                        control.write_cop0 = 1'b1;
                    end
                end
                default: control = '0;
            endcase
        end
    end

    // a single access per instruction at the memory stage
    always_comb begin
        assert #0 (!(control.mem_read && control.mem_write))
            else $error("decoder raised mem_read and mem_write together");
    end

endmodule

`default_nettype wire

// File: design/register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module register_file (
    input  logic                   pif,
    input  logic                   rst_n,
    writeback_if.gpr               wb,
    input  logic [`REG_ADDR_W-1:0] raddr_a,
    input  logic [`REG_ADDR_W-1:0] raddr_b,
    output logic [`DATA_W-1:0]     rdata_a,
    output logic [`DATA_W-1:0]     rdata_b
);

    logic [`DATA_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge pif or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.write_reg && wb.dest_reg != '0) begin // r0 stays zero
            regs[wb.dest_reg] <= wb.dest_reg_data;
        end
    end

    assign rdata_a = (raddr_a == '0) ? '0 : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0 : regs[raddr_b];

    // later stages must be flushed while the core is held in reset
    assert property (@(posedge pif) !rst_n |-> !wb.write_reg)
        else $error("register write during reset");

endmodule

`default_nettype wire

// File: design/register_cop0.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module register_cop0 (
    input  logic                      pif,
    input  logic                      rst_n,
    writeback_if.cop0                 wb,
    input  logic [`REG_ADDR_W-1:0]    read_rd,
    input  logic [isa_pkg::SEL_W-1:0] read_sel,
    output logic [`DATA_W-1:0]        rdata
);

    // only select 0 is backed by storage
    logic [`DATA_W-1:0] regs [`REG_COUNT];

    always_ff @(posedge pif or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.write_cop0 && wb.dest_cop0_sel == '0) begin
            regs[wb.dest_cop0_rd] <= wb.dest_cop0_data;
        end
    end

    assign rdata = (read_sel == '0) ? regs[read_rd] : '0; // other selects read zero

endmodule

`default_nettype wire

// File: design/operand_forwarder.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module operand_forwarder (
    input  logic [`REG_ADDR_W-1:0] rs,
    input  logic [`REG_ADDR_W-1:0] rt,
    input  logic [`DATA_W-1:0]     rf_rs,
    input  logic [`DATA_W-1:0]     rf_rt,
    input  pipe_pkg::fwd_t         fwd_ex,
    input  pipe_pkg::fwd_t         fwd_mem,
    writeback_if.bypass            wb,
    input  logic [`DATA_W-1:0]     hi_reg,
    input  logic [`DATA_W-1:0]     lo_reg,
    output logic [`DATA_W-1:0]     rs_out,
    output logic [`DATA_W-1:0]     rt_out,
    output logic [`DATA_W-1:0]     hi_out,
    output logic [`DATA_W-1:0]     lo_out
);

    pipe_pkg::fwd_t fwd_wb;

    function automatic logic hit(input pipe_pkg::fwd_t src, input logic [`REG_ADDR_W-1:0] idx);
        return src.valid && idx != '0 && src.idx == idx;
    endfunction

    // youngest result first
    function automatic logic [`DATA_W-1:0] pick(input logic [`REG_ADDR_W-1:0] idx,
                                                 input logic [`DATA_W-1:0] stored);
        if (idx == '0) return '0;
        if (hit(fwd_ex, idx)) return fwd_ex.data;
        if (hit(fwd_mem, idx)) return fwd_mem.data;
        if (hit(fwd_wb, idx)) return fwd_wb.data;
        return stored;
    endfunction

    assign fwd_wb = '{valid: wb.write_reg, idx: wb.dest_reg, data: wb.dest_reg_data};

    always_comb begin
        rs_out = pick(rs, rf_rs);
        rt_out = pick(rt, rf_rt);
    end

    assign hi_out = wb.write_hi ? wb.dest_hi_data : hi_reg; // hi/lo only seen at writeback
    assign lo_out = wb.write_lo ? wb.dest_lo_data : lo_reg;

endmodule

`default_nettype wire

// File: design/stage_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module stage_decode (
    input  logic                      pif,
    input  logic                      rst_n,
    input  logic [`DATA_W-1:0]        in_instruction,
    input  logic [`DATA_W-1:0]        in_pc,
    input  logic                      stall,
    input  logic                      bubble,
    input  logic                      nullify,
    input  logic                      wb_write_reg,
    input  logic [`REG_ADDR_W-1:0]    wb_dest_reg,
    input  logic [`DATA_W-1:0]        wb_dest_data,
    input  logic                      wb_write_cop0,
    input  logic [`REG_ADDR_W-1:0]    wb_cop0_rd,
    input  logic [isa_pkg::SEL_W-1:0] wb_cop0_sel,
    input  logic [`DATA_W-1:0]        wb_cop0_data,
    input  logic                      wb_write_hi,
    input  logic                      wb_write_lo,
    input  logic [`DATA_W-1:0]        wb_hi_data,
    input  logic [`DATA_W-1:0]        wb_lo_data,
    input  pipe_pkg::fwd_t            fwd_ex,
    input  pipe_pkg::fwd_t            fwd_mem,
    output logic [`DATA_W-1:0]        out_instruction,
    output logic [`DATA_W-1:0]        out_pc,
    output logic [`DATA_W-1:0]        out_pcsub4,
    output logic [`DATA_W-1:0]        out_pcadd4,
    output logic [`DATA_W-1:0]        out_pcadd8,
    output logic [`DATA_W-1:0]        out_pcjump,
    output logic [`DATA_W-1:0]        rs_data,
    output logic [`DATA_W-1:0]        rt_data,
    output logic [`DATA_W-1:0]        hi_data,
    output logic [`DATA_W-1:0]        lo_data,
    output logic [`DATA_W-1:0]        cop0_data,
    output logic [`REG_ADDR_W-1:0]    dest_cop0_rd,
    output logic [isa_pkg::SEL_W-1:0] dest_cop0_sel,
    output pipe_pkg::control_t        control
);

    isa_pkg::fields_t   f;
    logic [`DATA_W-1:0] rf_rs, rf_rt;
    logic [`DATA_W-1:0] hi_reg, lo_reg;

    writeback_if wb_bus ();

    assign wb_bus.write_reg      = wb_write_reg;
    assign wb_bus.dest_reg       = wb_dest_reg;
    assign wb_bus.dest_reg_data  = wb_dest_data;
    assign wb_bus.write_cop0     = wb_write_cop0;
    assign wb_bus.dest_cop0_rd   = wb_cop0_rd;
    assign wb_bus.dest_cop0_sel  = wb_cop0_sel;
    assign wb_bus.dest_cop0_data = wb_cop0_data;
    assign wb_bus.write_hi       = wb_write_hi;
    assign wb_bus.write_lo       = wb_write_lo;
    assign wb_bus.dest_hi_data   = wb_hi_data;
    assign wb_bus.dest_lo_data   = wb_lo_data;

    // stage register priority nullify > stall > bubble > load
    always_ff @(posedge pif or negedge rst_n) begin
        if (!rst_n) begin
            out_instruction <= '0;
            out_pc          <= `RESET_PC;
            out_pcsub4      <= `RESET_PC - `DATA_W'd4;
            out_pcadd4      <= `RESET_PC + `DATA_W'd4;
            out_pcadd8      <= `RESET_PC + `DATA_W'd8;
        end else if (nullify || (!stall && bubble)) begin
            out_instruction <= '0; // nop with pc values kept
        end else if (!stall) begin
            out_instruction <= in_instruction;
            out_pc          <= in_pc;
            out_pcsub4      <= in_pc - `DATA_W'd4;
            out_pcadd4      <= in_pc + `DATA_W'd4;
            out_pcadd8      <= in_pc + `DATA_W'd8;
        end
    end

    always_ff @(posedge pif or negedge rst_n) begin
        if (!rst_n) begin
            hi_reg <= '0;
            lo_reg <= '0;
        end else begin
            if (wb_bus.write_hi) hi_reg <= wb_bus.dest_hi_data;
            if (wb_bus.write_lo) lo_reg <= wb_bus.dest_lo_data;
        end
    end

    assign f          = isa_pkg::unpack(out_instruction);
    assign out_pcjump = {out_pcadd4[`DATA_W-1 -: 4], out_instruction[25:0], 2'b00}; // region jump

    assign dest_cop0_rd  = f.rd;
    assign dest_cop0_sel = f.sel;

    main_decoder i_main_decoder (
        .instruction (out_instruction),
        .control     (control)
    );

    register_file i_register_file (
        .pif     (pif),
        .rst_n   (rst_n),
        .wb      (wb_bus.gpr),
        .raddr_a (f.rs),
        .raddr_b (f.rt),
        .rdata_a (rf_rs),
        .rdata_b (rf_rt)
    );

    register_cop0 i_register_cop0 (
        .pif      (pif),
        .rst_n    (rst_n),
        .wb       (wb_bus.cop0),
        .read_rd  (f.rd),
        .read_sel (f.sel),
        .rdata    (cop0_data)
    );

    operand_forwarder i_operand_forwarder (
        .rs      (f.rs),
        .rt      (f.rt),
        .rf_rs   (rf_rs),
        .rf_rt   (rf_rt),
        .fwd_ex  (fwd_ex),
        .fwd_mem (fwd_mem),
        .wb      (wb_bus.bypass),
        .hi_reg  (hi_reg),
        .lo_reg  (lo_reg),
        .rs_out  (rs_data),
        .rt_out  (rt_data),
        .hi_out  (hi_data),
        .lo_out  (lo_data)
    );

    // the hazard unit only bubbles a stalled stage when it also flushes it
    assert property (@(posedge pif) disable iff (!rst_n) (stall && bubble) |-> nullify)
        else $error("stall and bubble raised together without nullify");

endmodule

`default_nettype wire

// File: sim/tb_stage_decode.sv
`timescale 1ns/1ns
`default_nettype none

`include "decode_macros.svh"

module tb_stage_decode;

    localparam int CYCLES     = 3000;
    localparam int TIMEOUT_NS = (CYCLES + 20) * 10; // reset, stimulus and drain, plus margin

    localparam logic [5:0] OPCODES [14] = '{isa_pkg::SPECIAL, isa_pkg::J, isa_pkg::JAL,
        isa_pkg::BEQ, isa_pkg::BNE, isa_pkg::ADDIU, isa_pkg::SLTI, isa_pkg::ANDI, isa_pkg::ORI,
        isa_pkg::LUI, isa_pkg::COP0, isa_pkg::LW, isa_pkg::SW, 6'h3f};
    localparam logic [5:0] FUNCTS [13] = '{isa_pkg::ADDU, isa_pkg::SUBU, isa_pkg::AND,
        isa_pkg::OR, isa_pkg::SLT, isa_pkg::SLL, isa_pkg::JR, isa_pkg::MFHI, isa_pkg::MFLO,
        isa_pkg::MTHI, isa_pkg::MTLO, isa_pkg::MULT, 6'h3f};

    logic pif = 1'b0;
    logic rst_n;
    logic [`DATA_W-1:0] in_instruction, in_pc;
    logic stall, bubble, nullify;
    logic wb_write_reg, wb_write_cop0, wb_write_hi, wb_write_lo;
    logic [`REG_ADDR_W-1:0] wb_dest_reg, wb_cop0_rd;
    logic [isa_pkg::SEL_W-1:0] wb_cop0_sel;
    logic [`DATA_W-1:0] wb_dest_data, wb_cop0_data, wb_hi_data, wb_lo_data;
    pipe_pkg::fwd_t fwd_ex, fwd_mem;
    logic [`DATA_W-1:0] out_instruction, out_pc, out_pcsub4, out_pcadd4, out_pcadd8, out_pcjump;
    logic [`DATA_W-1:0] rs_data, rt_data, hi_data, lo_data, cop0_data;
    logic [`REG_ADDR_W-1:0] dest_cop0_rd;
    logic [isa_pkg::SEL_W-1:0] dest_cop0_sel;
    pipe_pkg::control_t control;

    integer seed = 35;
    int errors = 0;

    // reference model state
    logic [`DATA_W-1:0] m_regs [`REG_COUNT];
    logic [`DATA_W-1:0] m_cop0 [`REG_COUNT];
    logic [`DATA_W-1:0] m_hi, m_lo, m_instr, m_pc;
    logic [`DATA_W-1:0] exp_rs, exp_rt, exp_hi, exp_lo, exp_cop0, exp_pcadd4;
    pipe_pkg::control_t exp_ctrl;
    pipe_pkg::fwd_t wb_src;

    stage_decode i_stage_decode (.*);

    always #5 pif = ~pif;

    function automatic int unsigned random_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // flag bits in order use_imm sign_ext write_reg dest_is_rt _ mem_read mem_write branch
    //   jump _ jump_reg link write_hi write_lo _ read_cop0 write_cop0
    function automatic pipe_pkg::control_t decode_ref(input logic [`DATA_W-1:0] word);
        logic [5:0] op;
        logic [5:0] fn;
        op = word[31:26];
        fn = word[5:0];
        if (word == '0) return '0; // pipeline nop
        case (op)
            isa_pkg::SPECIAL: begin
                case (fn)
                    isa_pkg::ADDU: return {pipe_pkg::ADD, 14'b0010_0000_0000_00};
                    isa_pkg::SUBU: return {pipe_pkg::SUB, 14'b0010_0000_0000_00};
                    isa_pkg::AND:  return {pipe_pkg::AND, 14'b0010_0000_0000_00};
                    isa_pkg::OR:   return {pipe_pkg::OR, 14'b0010_0000_0000_00};
                    isa_pkg::SLT:  return {pipe_pkg::SLT, 14'b0010_0000_0000_00};
                    isa_pkg::SLL:  return {pipe_pkg::SLL, 14'b0010_0000_0000_00};
                    isa_pkg::MFHI, isa_pkg::MFLO: return {pipe_pkg::PASS, 14'b0010_0000_0000_00};
                    isa_pkg::JR:   return {pipe_pkg::NOP, 14'b0000_0000_1000_00};
                    isa_pkg::MTHI: return {pipe_pkg::PASS, 14'b0000_0000_0010_00};
                    isa_pkg::MTLO: return {pipe_pkg::PASS, 14'b0000_0000_0001_00};
                    isa_pkg::MULT: return {pipe_pkg::NOP, 14'b0000_0000_0011_00};
                    default:       return '0;
                endcase
            end
            isa_pkg::J:     return {pipe_pkg::NOP, 14'b0000_0001_0000_00};
            isa_pkg::JAL:   return {pipe_pkg::NOP, 14'b0010_0001_0100_00};
            isa_pkg::BEQ, isa_pkg::BNE: return {pipe_pkg::SUB, 14'b0000_0010_0000_00};
            isa_pkg::ADDIU: return {pipe_pkg::ADD, 14'b1111_0000_0000_00};
            isa_pkg::SLTI:  return {pipe_pkg::SLT, 14'b1111_0000_0000_00};
            isa_pkg::ANDI:  return {pipe_pkg::AND, 14'b1011_0000_0000_00};
            isa_pkg::ORI:   return {pipe_pkg::OR, 14'b1011_0000_0000_00};
            isa_pkg::LUI:   return {pipe_pkg::LUI, 14'b1011_0000_0000_00};
            isa_pkg::LW:    return {pipe_pkg::ADD, 14'b1111_1000_0000_00};
            isa_pkg::SW:    return {pipe_pkg::ADD, 14'b1100_0100_0000_00};
            isa_pkg::COP0: begin
                if (word[25:21] == isa_pkg::COP0_MF)
                    return {pipe_pkg::PASS, 14'b0011_0000_0000_10};
                if (word[25:21] == isa_pkg::COP0_MT)
                    return {pipe_pkg::PASS, 14'b0000_0000_0000_01};
                return '0;
            end
            default: return '0;
        endcase
    endfunction

    // execute, then memory, then writeback, then stored value
    function automatic logic [`DATA_W-1:0] operand_value(input logic [`REG_ADDR_W-1:0] idx,
            input logic [`DATA_W-1:0] stored, input pipe_pkg::fwd_t ex, mem, wb);
        if (idx == '0) return '0;
        if (ex.valid && ex.idx == idx) return ex.data;
        if (mem.valid && mem.idx == idx) return mem.data;
        if (wb.valid && wb.idx == idx) return wb.data;
        return stored;
    endfunction

    task automatic count_mismatch(input string name, input logic [`DATA_W-1:0] expected,
                                  input logic [`DATA_W-1:0] actual);
        errors++;
        $display("FAILED %s expected %h actual %h", name, expected, actual);
    endtask

    task automatic count_failure(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    task automatic drive_cycle();
        logic [`DATA_W-1:0] word;
        logic hold;
        word = $random(seed);
        word[31:26] = OPCODES[random_below(14)];
        word[25:21] = 5'(random_below(8)); // small index range gives frequent hits
        word[20:16] = 5'(random_below(8));
        word[15:11] = 5'(random_below(8));
        if (word[31:26] == isa_pkg::SPECIAL) word[5:0] = FUNCTS[random_below(13)];
        if (word[31:26] == isa_pkg::COP0) begin
            if (random_below(3) != 0) begin
                word[25:21] = random_below(2) ? isa_pkg::COP0_MT : isa_pkg::COP0_MF;
            end
            if (random_below(2) != 0) word[2:0] = '0;
        end
        hold = (random_below(4) == 0);
        in_instruction <= word;
        in_pc          <= $unsigned($random(seed)) & ~32'h3;
        stall          <= hold;
        bubble         <= !hold && random_below(8) == 0; // hazard unit never stalls into a bubble
        nullify        <= (random_below(16) == 0);
        wb_write_reg   <= (random_below(2) != 0);
        wb_dest_reg    <= 5'(random_below(8));
        wb_dest_data   <= $random(seed);
        wb_write_cop0  <= (random_below(3) == 0);
        wb_cop0_rd     <= 5'(random_below(8));
        wb_cop0_sel    <= random_below(2) ? '0 : 3'(random_below(8));
        wb_cop0_data   <= $random(seed);
        wb_write_hi    <= (random_below(4) == 0);
        wb_write_lo    <= (random_below(4) == 0);
        wb_hi_data     <= $random(seed);
        wb_lo_data     <= $random(seed);
        fwd_ex         <= '{valid: random_below(3) == 0, idx: 5'(random_below(8)),
                            data: $random(seed)};
        fwd_mem        <= '{valid: random_below(3) == 0, idx: 5'(random_below(8)),
                            data: $random(seed)};
    endtask

    always @(posedge pif or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                m_regs[i] <= '0;
                m_cop0[i] <= '0;
            end
            m_hi    <= '0;
            m_lo    <= '0;
            m_instr <= '0;
            m_pc    <= `RESET_PC;
        end else begin
            if (wb_write_reg && wb_dest_reg != '0) m_regs[wb_dest_reg] <= wb_dest_data;
            if (wb_write_cop0 && wb_cop0_sel == '0) m_cop0[wb_cop0_rd] <= wb_cop0_data;
            if (wb_write_hi) m_hi <= wb_hi_data;
            if (wb_write_lo) m_lo <= wb_lo_data;
            if (nullify || (!stall && bubble)) begin
                m_instr <= '0; // pc kept
            end else if (!stall) begin
                m_instr <= in_instruction;
                m_pc    <= in_pc;
            end
        end
    end

    assign wb_src     = '{valid: wb_write_reg, idx: wb_dest_reg, data: wb_dest_data};
    assign exp_rs     = operand_value(m_instr[25:21], m_regs[m_instr[25:21]],
                                      fwd_ex, fwd_mem, wb_src);
    assign exp_rt     = operand_value(m_instr[20:16], m_regs[m_instr[20:16]],
                                      fwd_ex, fwd_mem, wb_src);
    assign exp_hi     = wb_write_hi ? wb_hi_data : m_hi;
    assign exp_lo     = wb_write_lo ? wb_lo_data : m_lo;
    assign exp_cop0   = (m_instr[2:0] == '0) ? m_cop0[m_instr[15:11]] : '0;
    assign exp_pcadd4 = m_pc + 32'd4;
    assign exp_ctrl   = decode_ref(m_instr);

    a_reset: assert property (@(posedge pif) $rose(rst_n) |->
                 out_instruction == '0 && control == '0 && out_pc == `RESET_PC)
        else count_failure("stage register not in its reset state after reset");
    a_nop: assert property (@(posedge pif) disable iff (!rst_n)
               (bubble || nullify) |=> out_instruction == '0)
        else count_mismatch("nop after bubble or nullify", '0, $sampled(out_instruction));
    a_nop_ctrl: assert property (@(posedge pif) disable iff (!rst_n)
                    out_instruction == '0 |-> control == '0)
        else count_mismatch("nop control", '0, 32'($sampled(control)));
    a_stall: assert property (@(posedge pif) disable iff (!rst_n) (stall && !nullify) |=>
                 $stable(out_instruction) && $stable(out_pc) && $stable(out_pcadd4) &&
                 $stable(out_pcadd8))
        else count_failure("stage outputs changed while stalled");
    a_instr: assert property (@(posedge pif) disable iff (!rst_n) out_instruction == m_instr)
        else count_mismatch("instruction", $sampled(m_instr), $sampled(out_instruction));
    a_ctrl: assert property (@(posedge pif) disable iff (!rst_n) control == exp_ctrl)
        else count_mismatch("control", 32'($sampled(exp_ctrl)), 32'($sampled(control)));
    a_pc: assert property (@(posedge pif) disable iff (!rst_n)
              out_pc == m_pc && out_pcsub4 == m_pc - 32'd4)
        else count_mismatch("pc", $sampled(m_pc), $sampled(out_pc));
    a_pcadd4: assert property (@(posedge pif) disable iff (!rst_n) out_pcadd4 == exp_pcadd4)
        else count_mismatch("pcadd4", $sampled(exp_pcadd4), $sampled(out_pcadd4));
    a_pcadd8: assert property (@(posedge pif) disable iff (!rst_n) out_pcadd8 == m_pc + 32'd8)
        else count_mismatch("pcadd8", $sampled(m_pc + 32'd8), $sampled(out_pcadd8));
    a_pcjump: assert property (@(posedge pif) disable iff (!rst_n)
                  out_pcjump == {exp_pcadd4[31:28], m_instr[25:0], 2'b00})
        else count_mismatch("pcjump", $sampled({exp_pcadd4[31:28], m_instr[25:0], 2'b00}),
                            $sampled(out_pcjump));
    a_rs: assert property (@(posedge pif) disable iff (!rst_n) rs_data == exp_rs)
        else count_mismatch("rs_data", $sampled(exp_rs), $sampled(rs_data));
    a_rt: assert property (@(posedge pif) disable iff (!rst_n) rt_data == exp_rt)
        else count_mismatch("rt_data", $sampled(exp_rt), $sampled(rt_data));
    a_r0: assert property (@(posedge pif) disable iff (!rst_n)
              out_instruction[25:21] == '0 |-> rs_data == '0)
        else count_mismatch("r0 read", '0, $sampled(rs_data));
    a_hi: assert property (@(posedge pif) disable iff (!rst_n) hi_data == exp_hi)
        else count_mismatch("hi_data", $sampled(exp_hi), $sampled(hi_data));
    a_lo: assert property (@(posedge pif) disable iff (!rst_n) lo_data == exp_lo)
        else count_mismatch("lo_data", $sampled(exp_lo), $sampled(lo_data));
    a_cop0: assert property (@(posedge pif) disable iff (!rst_n) cop0_data == exp_cop0)
        else count_mismatch("cop0_data", $sampled(exp_cop0), $sampled(cop0_data));
    a_cop0_dest: assert property (@(posedge pif) disable iff (!rst_n)
                     dest_cop0_rd == m_instr[15:11] && dest_cop0_sel == m_instr[2:0])
        else count_mismatch("cop0 dest", 32'($sampled({m_instr[15:11], m_instr[2:0]})),
                            32'($sampled({dest_cop0_rd, dest_cop0_sel})));

    initial begin
        rst_n = 1'b0;
        {in_instruction, in_pc, stall, bubble, nullify} = '0;
        {wb_write_reg, wb_dest_reg, wb_dest_data, wb_write_cop0, wb_cop0_rd} = '0;
        {wb_cop0_sel, wb_cop0_data, wb_write_hi, wb_write_lo, wb_hi_data, wb_lo_data} = '0;
        fwd_ex  = '0;
        fwd_mem = '0;
        repeat (2) @(posedge pif);
        rst_n <= 1'b1;
        repeat (CYCLES) begin
            @(posedge pif);
            drive_cycle();
        end
        repeat (2) @(posedge pif);
        #1; // let the last assertion actions run
        $display("checks failed: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the stimulus finished");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/writeback_if.sv
design/main_decoder.sv
design/register_file.sv
design/register_cop0.sv
design/operand_forwarder.sv
design/stage_decode.sv
sim/tb_stage_decode.sv

// File: Bender.yml
package:
  name: stage_decode

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/isa_pkg.sv
      - design/pipe_pkg.sv
      - design/writeback_if.sv
      - design/main_decoder.sv
      - design/register_file.sv
      - design/register_cop0.sv
      - design/operand_forwarder.sv
      - design/stage_decode.sv
  - target: simulation
    include_dirs:
      - design
    files:
      - sim/tb_stage_decode.sv
